// File: common/vid_config.svh
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// Pixel FIFO entries, also the fetch credit pool
`define VID_FIFO_DEPTH 16

// Pixel and line counter width
`define VID_CNT_W 13

// Pixel divider field width
`define VID_DIV_W 6

// Register map, byte addresses
`define VID_REG_CR      32'h0000_0000
`define VID_REG_H1      32'h0000_0028
`define VID_REG_H2      32'h0000_0030
`define VID_REG_V1      32'h0000_0038
`define VID_REG_V2      32'h0000_0040
`define VID_REG_BASE    32'h0000_0048
`define VID_REG_LINEINC 32'h0000_0050

// CR field positions
`define VID_CR_EN_BIT  3
`define VID_CR_DIV_LSB 4

`endif

// File: common/vid_bus_pkg.sv
`default_nettype none

package vid_bus_pkg;

    // Single-cycle host register write
    typedef struct packed {
        logic        valid; // Write strobe
        logic [31:0] addr;  // Register byte address
        logic [31:0] data;  // Write data
    } host_wr_t;

    // Memory read request, no stall
    typedef struct packed {
        logic        valid; // Read issued this cycle
        logic [31:0] addr;  // Byte address
    } mem_req_t;

    // Memory read response, in request order
    typedef struct packed {
        logic        valid; // Data returned this cycle
        logic [31:0] data;  // Word, RGB in low 24 bits
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: common/vid_disp_pkg.sv
`default_nettype none

`include "vid_config.svh"

package vid_disp_pkg;

    typedef logic [`VID_CNT_W-1:0] cnt_t;   // Pixel or line index
    typedef logic [`VID_DIV_W-1:0] div_t;   // Pixel divider

    // Raster timing, unpacked from H1/H2/V1/V2 and CR
    typedef struct packed {
        cnt_t hend;        // Last pixel index of a line
        cnt_t hsize;       // Active pixels per line
        cnt_t hsync_start; // First hsync pixel
        cnt_t hsync_end;   // First pixel after hsync
        cnt_t vend;        // Last line index of a frame
        cnt_t vsize;       // Active lines per frame
        cnt_t vsync_start; // First vsync line
        cnt_t vsync_end;   // First line after vsync
        div_t pix_div;     // Tick every pix_div+1 clocks
    } timing_cfg_t;

    // Frame location in memory
    typedef struct packed {
        logic [31:0] base;    // Byte address of pixel 0, line 0
        logic [31:0] lineinc; // Bytes between line starts
    } fetch_cfg_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // Registered display output
    typedef struct packed {
        logic   hsync;
        logic   hblank;
        logic   vsync;
        logic   vblank;
        pixel_t pixel;
    } video_out_t;

endpackage

`default_nettype wire

// File: src/vid_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_config.svh"

module vid_regs
    import vid_bus_pkg::*;
    import vid_disp_pkg::*;
(
    input  wire        clk,
    input  wire        reset_n,
    input  wire        host_wr_t host,
    output logic       enable,
    output logic       restart,
    output timing_cfg_t timing_cfg,
    output fetch_cfg_t  fetch_cfg
);

    localparam int W = `VID_CNT_W;

    logic [31:0] h1_q;      // hsize | hend
    logic [31:0] h2_q;      // hsync start | hsync end
    logic [31:0] v1_q;      // vsize | vend
    logic [31:0] v2_q;      // vsync start | vsync end
    logic [31:0] base_q;
    logic [31:0] lineinc_q;
    div_t        pix_div_q; // CR divider field

    logic wr_cr;

    assign wr_cr = host.valid && (host.addr == `VID_REG_CR);

    // Control state, CR write also restarts the frame
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable    <= 1'b0;
            pix_div_q <= '0;
            restart   <= 1'b0;
        end else begin
            restart <= wr_cr; // One-cycle pulse, aligned with new CR
            if (wr_cr) begin
                enable    <= host.data[`VID_CR_EN_BIT];
                pix_div_q <= host.data[`VID_CR_DIV_LSB +: `VID_DIV_W];
            end
        end
    end

    // Configuration words, unknown addresses fall through
    always_ff @(posedge clk) begin
        if (host.valid) begin
            case (host.addr)
                `VID_REG_H1:      h1_q      <= host.data;
                `VID_REG_H2:      h2_q      <= host.data;
                `VID_REG_V1:      v1_q      <= host.data;
                `VID_REG_V2:      v2_q      <= host.data;
                `VID_REG_BASE:    base_q    <= host.data;
                `VID_REG_LINEINC: lineinc_q <= host.data;
                default: ;
            endcase
        end
    end

    // Field unpack, same split for horizontal and vertical words
    always_comb begin
        timing_cfg.hend        = h1_q[W-1:0];
        timing_cfg.hsize       = h1_q[2*W-1:W];
        timing_cfg.hsync_end   = h2_q[W-1:0];
        timing_cfg.hsync_start = h2_q[2*W-1:W];
        timing_cfg.vend        = v1_q[W-1:0];
        timing_cfg.vsize       = v1_q[2*W-1:W];
        timing_cfg.vsync_end   = v2_q[W-1:0];
        timing_cfg.vsync_start = v2_q[2*W-1:W];
        timing_cfg.pix_div     = pix_div_q;
        fetch_cfg.base         = base_q;
        fetch_cfg.lineinc      = lineinc_q;
    end

endmodule

`default_nettype wire

// File: src/vid_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vid_timing
    import vid_disp_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    input  wire         enable,
    input  wire         restart,
    input  wire timing_cfg_t timing_cfg,
    output logic        pop,
    input  wire pixel_t fifo_head,
    input  wire         fifo_empty,
    output video_out_t  video,
    output logic        underrun
);

    logic run;      // Set once the first pixel has landed
    div_t div_cnt;  // Clocks within the current pixel period
    cnt_t hcnt;     // Pixel index within the line
    cnt_t vcnt;     // Line index within the frame

    logic tick;
    logic h_active;
    logic v_active;
    logic hsync_nxt;
    logic vsync_nxt;
    logic h_last;
    logic v_last;

    always_comb begin
        tick      = run && (div_cnt == timing_cfg.pix_div);
        h_active  = hcnt < timing_cfg.hsize;
        v_active  = vcnt < timing_cfg.vsize;
        hsync_nxt = (hcnt >= timing_cfg.hsync_start) && (hcnt < timing_cfg.hsync_end);
        vsync_nxt = (vcnt >= timing_cfg.vsync_start) && (vcnt < timing_cfg.vsync_end);
        h_last    = hcnt == timing_cfg.hend;
        v_last    = vcnt == timing_cfg.vend;
        pop       = tick && h_active && v_active; // One pop per active pixel
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            run      <= 1'b0;
            div_cnt  <= '0;
            hcnt     <= '0;
            vcnt     <= '0;
            video    <= '0;
            underrun <= 1'b0;
        end else if (!enable || restart) begin
            run     <= 1'b0; // Back to pixel 0 of line 0
            div_cnt <= '0;
            hcnt    <= '0;
            vcnt    <= '0;
            video   <= '0;
            if (restart) begin
                underrun <= 1'b0;
            end
        end else begin
            if (!run && !fifo_empty) begin
                run <= 1'b1; // Wait for the first fetched pixel
            end
            if (tick) begin
                div_cnt      <= '0;
                video.hsync  <= hsync_nxt;
                video.hblank <= !h_active;
                video.vsync  <= vsync_nxt;
                video.vblank <= !v_active;
                // Zero pixel in blanking or on underrun
                video.pixel  <= (pop && !fifo_empty) ? fifo_head : '0;
                if (pop && fifo_empty) begin
                    underrun <= 1'b1; // Sticky until restart
                end
                if (h_last) begin
                    hcnt <= '0;
                    vcnt <= v_last ? '0 : vcnt + 1'b1;
                end else begin
                    hcnt <= hcnt + 1'b1;
                end
            end else if (run) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/vid_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_config.svh"

module vid_fetch
    import vid_bus_pkg::*;
    import vid_disp_pkg::*;
(
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  enable,
    input  wire                  restart,
    input  wire fetch_cfg_t      fetch_cfg,
    input  wire [`VID_CNT_W-1:0] hsize,
    input  wire [`VID_CNT_W-1:0] vsize,
    input  wire                  credit_return,
    output mem_req_t             mem_req
);

    localparam int CRW = $clog2(`VID_FIFO_DEPTH + 1);
    localparam int PADW = 32 - `VID_CNT_W - 2;

    logic [CRW-1:0] credits;   // Free FIFO slots not yet claimed
    cnt_t           col;       // Next pixel within the line
    cnt_t           line;      // Next line within the frame
    logic [31:0]    line_addr; // Byte address of current line start

    logic issue;
    logic col_last;
    logic line_last;

    always_comb begin
        issue     = enable && !restart && (credits != '0); // No stall on memory side
        col_last  = col == hsize - 1'b1;
        line_last = line == vsize - 1'b1;
        mem_req.valid = issue;
        mem_req.addr  = line_addr + {{PADW{1'b0}}, col, 2'b00}; // 4 bytes per pixel
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credits   <= CRW'(`VID_FIFO_DEPTH);
            col       <= '0;
            line      <= '0;
            line_addr <= '0;
        end else if (!enable || restart) begin
            credits   <= CRW'(`VID_FIFO_DEPTH); // Full pool, FIFO flushed alongside
            col       <= '0;
            line      <= '0;
            line_addr <= fetch_cfg.base;
        end else begin
            credits <= credits - CRW'(issue) + CRW'(credit_return);
            if (issue) begin
                if (col_last) begin
                    col <= '0;
                    if (line_last) begin
                        line      <= '0;
                        line_addr <= fetch_cfg.base; // Next frame
                    end else begin
                        line      <= line + 1'b1;
                        line_addr <= line_addr + fetch_cfg.lineinc;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: fifo/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo
    import vid_bus_pkg::*;
    import vid_disp_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  wire           clk,
    input  wire           reset_n,
    input  wire           flush,
    input  wire mem_rsp_t push,
    input  wire           pop,
    output pixel_t        head,
    output logic          empty,
    output logic          credit_return
);

    localparam int AW = $clog2(DEPTH);

    pixel_t mem [DEPTH];   // Pixel storage, RGB only

    logic [AW:0] wr_ptr;   // MSB is the wrap bit
    logic [AW:0] rd_ptr;

    logic full;
    logic do_push;
    logic do_pop;

    always_comb begin
        empty = wr_ptr == rd_ptr;
        // Same index, opposite lap
        full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
        do_push = push.valid && !full;
        do_pop  = pop && !empty; // Pop on empty is dropped
        credit_return = do_pop;
        head  = mem[rd_ptr[AW-1:0]]; // Head shown without a read cycle
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= pixel_t'(push.data[23:0]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/vid_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_config.svh"

module vid_top
    import vid_bus_pkg::*;
    import vid_disp_pkg::*;
(
    input  wire           clk,
    input  wire           reset_n,
    input  wire host_wr_t host,
    output mem_req_t      mem_req,
    input  wire mem_rsp_t mem_rsp,
    output video_out_t    video,
    output logic          underrun
);

    logic        enable;
    logic        restart;
    timing_cfg_t timing_cfg;
    fetch_cfg_t  fetch_cfg;
    logic        pop;
    pixel_t      fifo_head;
    logic        fifo_empty;
    logic        credit_return;

    vid_regs u_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .host       (host),
        .enable     (enable),
        .restart    (restart),
        .timing_cfg (timing_cfg),
        .fetch_cfg  (fetch_cfg)
    );

    vid_fetch u_fetch (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable        (enable),
        .restart       (restart),
        .fetch_cfg     (fetch_cfg),
        .hsize         (timing_cfg.hsize),
        .vsize         (timing_cfg.vsize),
        .credit_return (credit_return),
        .mem_req       (mem_req)
    );

    // Responses push straight in, flushed on restart or while disabled
    pixel_fifo #(
        .DEPTH (`VID_FIFO_DEPTH)
    ) u_fifo (
        .clk           (clk),
        .reset_n       (reset_n),
        .flush         (restart | ~enable),
        .push          (mem_rsp),
        .pop           (pop),
        .head          (fifo_head),
        .empty         (fifo_empty),
        .credit_return (credit_return)
    );

    vid_timing u_timing (
        .clk        (clk),
        .reset_n    (reset_n),
        .enable     (enable),
        .restart    (restart),
        .timing_cfg (timing_cfg),
        .pop        (pop),
        .fifo_head  (fifo_head),
        .fifo_empty (fifo_empty),
        .video      (video),
        .underrun   (underrun)
    );

endmodule

`default_nettype wire

// File: tb/vid_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_config.svh"

module vid_tb
    import vid_bus_pkg::*;
    import vid_disp_pkg::*;
;

    localparam int NUM_ROWS     = 4;
    localparam int DRAIN_CYCLES = 32; // Covers 16 outstanding reads plus latency

    typedef struct packed {
        logic [31:0] hsize;
        logic [31:0] hend;
        logic [31:0] vsize;
        logic [31:0] vend;
        logic [31:0] hss;     // Hsync start pixel
        logic [31:0] hse;     // Hsync end pixel
        logic [31:0] vss;     // Vsync start line
        logic [31:0] vse;     // Vsync end line
        logic [31:0] div;
        logic [31:0] base;
        logic [31:0] lineinc;
        logic [31:0] frames;
    } row_t;

    logic       clk;
    logic       reset_n;
    host_wr_t   host;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    video_out_t video;
    logic       underrun;

    row_t        rows [NUM_ROWS];  // Stimulus table
    int          errors;
    int          cur;              // Row under test
    logic        tracking;         // Credit and pixel bookkeeping active
    logic        started;          // First real pixel seen
    logic        dis_check;        // Expect idle outputs
    logic        prev_act;
    pixel_t      prev_pix;
    int          run_len;          // Cycles the current pixel has held
    int          req_cnt;
    int          disp_cnt;
    logic [31:0] exp_col;
    logic [31:0] exp_line;

    logic [31:0] lfsr;             // Memory latency source
    logic [31:0] rsp_addr [$];
    int          rsp_due [$];
    int          mem_cyc;
    int          last_due;
    int          due;
    logic [1:0]  lat_bits;

    vid_top DUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .host     (host),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .video    (video),
        .underrun (underrun)
    );

    function automatic row_t make_row(input logic [31:0] hsize, hend, vsize, vend,
                                      input logic [31:0] hss, hse, vss, vse, div,
                                      input logic [31:0] base, lineinc, frames);
        make_row = '{hsize, hend, vsize, vend, hss, hse, vss, vse, div, base, lineinc, frames};
    endfunction

    // Right-shift Galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // Memory content with RGB in the low 24 bits
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        mem_word = (addr ^ 32'h00A5_A5A5) & 32'h00FF_FFFF;
    endfunction

    function automatic int timeout_limit();
        int total;
        total = 2000; // Reset, startup and margin
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += int'(rows[i].frames * (rows[i].hend + 1) * (rows[i].vend + 1)
                          * (rows[i].div + 1));
            total += 8 * 2 + DRAIN_CYCLES + 100; // Writes, drain, first fetch
        end
        timeout_limit = total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // One clock of output monitoring at the falling edge
    task automatic sample_cycle();
        logic        act;
        logic [31:0] exp_addr;
        @(negedge clk);
        act = !video.hblank && !video.vblank;
        if (tracking && mem_req.valid) begin
            req_cnt++;
        end
        if (dis_check) begin
            check_value("idle video", 32'd0, 32'(video));
            check_value("idle request", 32'd0, 32'(mem_req.valid));
            check_value("idle underrun", 32'd0, 32'(underrun));
        end
        if (tracking && !started && act && video.pixel != '0) begin
            started = 1'b1; // Zero pixel before the first tick is not a pixel
        end
        if (started) begin
            if (act && (!prev_act || video.pixel != prev_pix)) begin
                if (prev_act) begin
                    check_value($sformatf("row%0d pixel period", cur), rows[cur].div + 1,
                                run_len);
                end
                exp_addr = rows[cur].base + rows[cur].lineinc * exp_line + 4 * exp_col;
                check_value($sformatf("row%0d pixel %0d", cur, disp_cnt), mem_word(exp_addr),
                            32'(video.pixel));
                disp_cnt++;
                run_len = 1;
                exp_col = exp_col + 1;
                if (exp_col == rows[cur].hsize) begin
                    exp_col  = 0;
                    exp_line = (exp_line + 1 == rows[cur].vsize) ? 32'd0 : exp_line + 1;
                end
            end else if (act) begin
                run_len++;
            end else if (prev_act) begin
                check_value($sformatf("row%0d pixel period", cur), rows[cur].div + 1, run_len);
            end
            prev_act = act;
            prev_pix = video.pixel;
        end
        if (tracking && (req_cnt - disp_cnt > `VID_FIFO_DEPTH)) begin
            errors++;
            $display("Credit overrun in row %0d: %0d reads issued against %0d pixels shown",
                     cur, req_cnt, disp_cnt);
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        sample_cycle();
        host.valid = 1'b1;
        host.addr  = addr;
        host.data  = data;
        sample_cycle();
        host.valid = 1'b0;
    endtask

    // Frame windows start at the first pixel of line 0
    task automatic run_frames(input int r);
        int line_len;
        int frame_len;
        int hs_cnt;
        int vs_cnt;
        int act_cnt;
        line_len  = int'((rows[r].hend + 1) * (rows[r].div + 1));
        frame_len = line_len * int'(rows[r].vend + 1);
        hs_cnt    = 0;
        vs_cnt    = 0;
        act_cnt   = 0;
        while (!started) begin
            sample_cycle(); // Watchdog bounds the wait
        end
        for (int c = 0; c < frame_len * int'(rows[r].frames); c++) begin
            if (c != 0) begin
                sample_cycle();
            end
            hs_cnt  += int'(video.hsync);
            vs_cnt  += int'(video.vsync);
            act_cnt += int'(!video.hblank && !video.vblank);
            if (c % line_len == line_len - 1) begin
                check_value($sformatf("row%0d hsync cycles", r),
                            (rows[r].hse - rows[r].hss) * (rows[r].div + 1), hs_cnt);
                hs_cnt = 0;
            end
            if (c % frame_len == frame_len - 1) begin
                check_value($sformatf("row%0d active cycles", r),
                            rows[r].hsize * rows[r].vsize * (rows[r].div + 1), act_cnt);
                check_value($sformatf("row%0d vsync cycles", r),
                            (rows[r].vse - rows[r].vss) * line_len, vs_cnt);
                vs_cnt  = 0;
                act_cnt = 0;
            end
        end
        check_value($sformatf("row%0d pixels shown", r),
                    rows[r].frames * rows[r].hsize * rows[r].vsize, disp_cnt);
        check_value($sformatf("row%0d underrun", r), 32'd0, 32'(underrun));
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // In-order read responses 1 to 4 cycles after the request
    always @(negedge clk) begin
        mem_cyc = mem_cyc + 1;
        if (rsp_due.size() != 0 && rsp_due[0] == mem_cyc) begin
            mem_rsp.valid = 1'b1;
            mem_rsp.data  = mem_word(rsp_addr.pop_front());
            void'(rsp_due.pop_front());
        end else begin
            mem_rsp.valid = 1'b0;
            mem_rsp.data  = '0;
        end
        if (mem_req.valid) begin
            lat_bits[0] = lfsr[0];
            lfsr        = lfsr_step(lfsr);
            lat_bits[1] = lfsr[0];
            lfsr        = lfsr_step(lfsr);
            due = mem_cyc + 1 + int'(lat_bits);
            if (due <= last_due) begin
                due = last_due + 1; // One response per cycle
            end
            last_due = due;
            rsp_addr.push_back(mem_req.addr);
            rsp_due.push_back(due);
        end
    end

    initial begin
        int wd_cycles;
        int limit;
        wd_cycles = 0;
        @(posedge clk);
        limit = timeout_limit();
        while (wd_cycles < limit) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rows[0] = make_row(8, 11, 4, 6, 9, 11, 5, 6, 3, 32'h0000_1000, 32'h40, 2);
        rows[1] = make_row(10, 13, 5, 7, 11, 13, 6, 7, 4, 32'h0002_0000, 32'h80, 2);
        rows[2] = make_row(6, 9, 3, 5, 7, 9, 4, 5, 5, 32'h0040_0100, 32'h100, 3);
        rows[3] = make_row(12, 15, 4, 6, 13, 15, 5, 6, 7, 32'h00FF_FFA0, 32'h30, 2); // Crosses 24 bits
        reset_n   = 1'b0;
        host      = '0;
        mem_rsp   = '0;
        lfsr      = 32'h519c5179;
        mem_cyc   = 0;
        last_due  = 0;
        errors    = 0;
        cur       = 0;
        tracking  = 1'b0;
        started   = 1'b0;
        dis_check = 1'b0;
        prev_act  = 1'b0;
        prev_pix  = '0;
        run_len   = 0;
        req_cnt   = 0;
        disp_cnt  = 0;
        exp_col   = 0;
        exp_line  = 0;
        repeat (16) @(negedge clk);
        reset_n   = 1'b1;
        dis_check = 1'b1; // Outputs low out of reset
        repeat (4) sample_cycle();
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur = r;
            write_reg(`VID_REG_V1, {6'd0, rows[r].vsize[12:0], rows[r].vend[12:0]});
            write_reg(`VID_REG_V2, {6'd0, rows[r].vss[12:0], rows[r].vse[12:0]});
            write_reg(`VID_REG_H1, {6'd0, rows[r].hsize[12:0], rows[r].hend[12:0]});
            write_reg(`VID_REG_H2, {6'd0, rows[r].hss[12:0], rows[r].hse[12:0]});
            write_reg(`VID_REG_BASE, rows[r].base);
            write_reg(`VID_REG_LINEINC, rows[r].lineinc);
            dis_check = 1'b0;
            tracking  = 1'b1; // Counts restart with the frame
            req_cnt   = 0;
            disp_cnt  = 0;
            exp_col   = 0;
            exp_line  = 0;
            prev_act  = 1'b0;
            write_reg(`VID_REG_CR, {22'd0, rows[r].div[5:0], 4'b1000});
            run_frames(r);
            tracking = 1'b0;
            started  = 1'b0;
            write_reg(`VID_REG_CR, 32'd0);
            dis_check = 1'b1; // Disable has reached the outputs
            repeat (DRAIN_CYCLES) sample_cycle();
        end
        $display("Run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/vid_bus_pkg.sv
common/vid_disp_pkg.sv
src/vid_regs.sv
src/vid_timing.sv
src/vid_fetch.sv
fifo/pixel_fifo.sv
src/vid_top.sv
tb/vid_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --top-module vid_tb -f all.f -o vid_sim > build.log 2>&1 &&
./obj_dir/vid_sim > sim.log 2>&1 &&
cat sim.log &&
! grep -q "TESTS FAILED" sim.log ||
{ echo "Simulation did not pass, see build.log and sim.log"; exit 1; }
